/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f sources.f --top-module pcMonTb -o pcMonSim > build.log 2>&1 \
   && ./obj_dir/pcMonSim > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null \
   ; grep -q "^Done: no errors$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* sources.f */
src/pcMonPkg.sv
src/traceCapture.sv
src/addressMatch.sv
src/verdictControl.sv
src/pcMonTop.sv
verif/pcMonTb.sv

/* src/addressMatch.sv */
// second monitor stage: compares the low pc bits with the pass/fail address table and registers the hits
module addressMatch #(
   parameter pcMonPkg::pc_t passAddr    = 64'h0000_0000_8000_0100,
   parameter pcMonPkg::pc_t failAddr    = 64'h0000_0000_8000_0200,
   parameter pcMonPkg::pc_t finishAddr  = '0,  // zero means no entry
   parameter pcMonPkg::pc_t toHostAddr  = '0,
   parameter pcMonPkg::pc_t failAltAddr = '0
) (
   input  logic                 dvtFlags,
   input  logic                 pcFail,
   input  pcMonPkg::capBeat_t   capBeat,
   input  logic                 checkToHost,
   output pcMonPkg::matchBeat_t matchBeat
);

   localparam int mb = pcMonPkg::matchBits;

   // ------------------------------
   // table, low bits only
   // ------------------------------
   localparam logic [mb-1:0] passLow    = passAddr[mb-1:0];
   localparam logic [mb-1:0] failLow    = failAddr[mb-1:0];
   localparam logic [mb-1:0] finishLow  = finishAddr[mb-1:0];
   localparam logic [mb-1:0] toHostLow  = toHostAddr[mb-1:0];
   localparam logic [mb-1:0] failAltLow = failAltAddr[mb-1:0];

   // optional entries are absent when their low bits are zero
   localparam bit haveFinish  = (finishLow != '0);
   localparam bit haveToHost  = (toHostLow != '0);
   localparam bit haveFailAlt = (failAltLow != '0);

   logic [mb-1:0] pcLow;
   logic          isPass;
   logic          isFinish;
   logic          isToHost;
   logic          isFail;
   logic          isFailAlt;
   logic          hitPass;
   logic          hitFail;

   assign pcLow = capBeat.pc[mb-1:0];

   // ------------------------------
   // compares
   // ------------------------------
   assign isPass    = (pcLow == passLow);
   assign isFinish  = haveFinish && (pcLow == finishLow);
   assign isToHost  = haveToHost && checkToHost && (pcLow == toHostLow);  // only when enabled
   assign isFail    = (pcLow == failLow);
   assign isFailAlt = haveFailAlt && (pcLow == failAltLow);

   // a hit needs a valid beat, the pc is stale otherwise
   assign hitPass = capBeat.valid && (isPass || isFinish || isToHost);
   assign hitFail = capBeat.valid && (isFail || isFailAlt);

   // ------------------------------
   // output register
   // ------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         matchBeat <= '0;
      end else begin
         matchBeat.valid    <= capBeat.valid;
         matchBeat.repeatPc <= capBeat.valid && capBeat.repeatPc;
         matchBeat.hitPass  <= hitPass;
         matchBeat.hitFail  <= hitFail;
      end
   end

   // ------------------------------
   // checks
   // ------------------------------

   // the verdict stage trusts hits without looking at valid again
   hitNeedsValid: assert property (
      @(posedge dvtFlags) disable iff (pcFail)
      !matchBeat.valid |-> !(matchBeat.hitPass || matchBeat.hitFail)
   ) else $error("addressMatch: table hit on an invalid beat");

endmodule

/* src/pcMonPkg.sv */
// shared widths and beat types of the retired-PC monitor, referenced everywhere as pcMonPkg::name
package pcMonPkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int pcWidth   = 64;  // full retired pc
   localparam int matchBits = 30;  // low pc bits checked against the address table

   // one retired program counter
   typedef logic [pcWidth-1:0] pc_t;

   // ------------------------------
   // pipeline beats
   // ------------------------------

   // raw retirement trace from the core, one beat per cycle
   typedef struct packed {
      logic valid;  // a pc retired this cycle
      pc_t  pc;
   } traceBeat_t;

   // registered trace plus the repeat flag
   typedef struct packed {
      logic valid;
      logic repeatPc;  // same pc as the last valid beat
      pc_t  pc;
   } capBeat_t;

   // table hits, the pc itself is no longer needed here
   typedef struct packed {
      logic valid;
      logic repeatPc;
      logic hitPass;   // pass, finish or to-host address
      logic hitFail;   // fail or alternate fail address
   } matchBeat_t;

   // ------------------------------
   // result
   // ------------------------------

   // latched test outcome, also the reset-status readback
   typedef struct packed {
      logic pass;
      logic fail;
   } verdict_t;

   // at most one of the two bits is ever set
   // a timeout clears pass and sets fail

endpackage

/* src/pcMonTop.sv */
// top of the retired-PC test monitor: holds the address table and chains capture, match and verdict
module pcMonTop #(
   parameter pcMonPkg::pc_t passAddr    = 64'h0000_0000_8000_0100,
   parameter pcMonPkg::pc_t failAddr    = 64'h0000_0000_8000_0200,
   parameter pcMonPkg::pc_t finishAddr  = '0,
   parameter pcMonPkg::pc_t toHostAddr  = '0,
   parameter pcMonPkg::pc_t failAltAddr = '0,
   parameter int            stuckLimit  = 500,
   parameter int            sleepCycles = 20
) (
   input  logic                 dvtFlags,
   input  logic                 pcFail,
   input  pcMonPkg::traceBeat_t trace,
   input  logic                 checkToHost,   // level, enables to-host matching
   input  logic                 timeoutPulse,  // one cycle, forces fail
   input  logic                 disableStuck,  // one cycle, sticky until reset
   output pcMonPkg::verdict_t   verdict,
   output logic                 stuck,
   output logic                 coreHold
);

   // ------------------------------
   // stage to stage beats
   // ------------------------------
   pcMonPkg::capBeat_t   capBeat;
   pcMonPkg::matchBeat_t matchBeat;

   // stage 1, register and repeat flag
   traceCapture uCapture (
      .dvtFlags (dvtFlags),
      .pcFail   (pcFail),
      .trace    (trace),
      .capBeat  (capBeat)
   );

   // stage 2, table compare
   addressMatch #(
      .passAddr    (passAddr),
      .failAddr    (failAddr),
      .finishAddr  (finishAddr),
      .toHostAddr  (toHostAddr),
      .failAltAddr (failAltAddr)
   ) uMatch (
      .dvtFlags    (dvtFlags),
      .pcFail      (pcFail),
      .capBeat     (capBeat),
      .checkToHost (checkToHost),
      .matchBeat   (matchBeat)
   );

   // stage 3, verdict, stuck and hold
   verdictControl #(
      .stuckLimit  (stuckLimit),
      .sleepCycles (sleepCycles)
   ) uVerdict (
      .dvtFlags     (dvtFlags),
      .pcFail       (pcFail),
      .matchBeat    (matchBeat),
      .timeoutPulse (timeoutPulse),
      .disableStuck (disableStuck),
      .verdict      (verdict),
      .stuck        (stuck),
      .coreHold     (coreHold)
   );

endmodule

/* src/traceCapture.sv */
// first monitor stage: registers each retired-pc beat and marks a repeat of the previous valid pc
module traceCapture (
   input  logic                 dvtFlags,
   input  logic                 pcFail,
   input  pcMonPkg::traceBeat_t trace,
   output pcMonPkg::capBeat_t   capBeat
);

   // ------------------------------
   // history of the last valid pc
   // ------------------------------
   pcMonPkg::pc_t lastPc;    // last valid pc seen
   logic          haveLast;  // lastPc holds a real value
   logic          isRepeat;

   // registered beat fields
   logic          capValid;
   logic          capRepeat;
   pcMonPkg::pc_t capPc;

   // no history right after reset, so the first pc is never a repeat
   assign isRepeat = trace.valid && haveLast && (trace.pc == lastPc);

   // ------------------------------
   // control flops
   // ------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         haveLast  <= 1'b0;
         capValid  <= 1'b0;
         capRepeat <= 1'b0;
      end else begin
         capValid  <= trace.valid;
         capRepeat <= isRepeat;
         if (trace.valid) haveLast <= 1'b1;
      end
   end

   // payload, only qualified by valid downstream
   always_ff @(posedge dvtFlags) begin
      capPc <= trace.pc;
      if (trace.valid) begin
         lastPc <= trace.pc;  // invalid cycles keep the old pc
      end
   end

   assign capBeat = '{valid: capValid, repeatPc: capRepeat, pc: capPc};

   // ------------------------------
   // checks
   // ------------------------------

   // an unknown valid would corrupt the repeat history and every later stage
   validKnown: assert property (
      @(posedge dvtFlags) disable iff (pcFail)
      !$isunknown(trace.valid)
   ) else $error("traceCapture: trace valid is unknown");

endmodule

/* src/verdictControl.sv */
// third monitor stage: stuck-pc counter, first-verdict latch with timeout override, and core hold countdown
module verdictControl #(
   parameter int stuckLimit  = 500,  // repeats in a row that count as a stuck core
   parameter int sleepCycles = 20    // cycles from verdict to core hold
) (
   input  logic                 dvtFlags,
   input  logic                 pcFail,
   input  pcMonPkg::matchBeat_t matchBeat,
   input  logic                 timeoutPulse,
   input  logic                 disableStuck,
   output pcMonPkg::verdict_t   verdict,
   output logic                 stuck,
   output logic                 coreHold
);

   localparam int cntWidth  = $clog2(stuckLimit + 1);
   localparam int holdWidth = $clog2(sleepCycles + 1);
   localparam logic [cntWidth-1:0]  cntLimit  = cntWidth'(stuckLimit);
   localparam logic [holdWidth-1:0] holdStart = holdWidth'(sleepCycles);

   logic [cntWidth-1:0]  stuckCnt;      // repeats in a row, saturates at the limit
   logic [cntWidth-1:0]  stuckCntNext;
   logic                 stuckOff;      // sticky disable
   logic                 stuckOffNext;
   logic                 stuckNext;
   logic                 decided;
   logic                 failNow;
   logic                 firstLatch;
   pcMonPkg::verdict_t   verdictNext;
   logic [holdWidth-1:0] holdCnt;       // zero when idle

   // ------------------------------
   // stuck detection
   // ------------------------------
   always_comb begin
      stuckCntNext = stuckCnt;
      if (matchBeat.valid) begin
         if (!matchBeat.repeatPc) begin
            stuckCntNext = '0;  // pc moved on
         end else if (stuckCnt < cntLimit) begin
            stuckCntNext = stuckCnt + 1'b1;
         end
      end
   end

   assign stuckOffNext = stuckOff || disableStuck;
   // value of stuck after this edge, so fail lands together with stuck
   assign stuckNext    = (stuckCntNext >= cntLimit) && !stuckOffNext;
   assign stuck        = (stuckCnt >= cntLimit) && !stuckOff;

   // ------------------------------
   // verdict
   // ------------------------------
   assign decided = verdict.pass || verdict.fail;
   assign failNow = matchBeat.hitFail || stuckNext;

   always_comb begin
      verdictNext = verdict;
      if (timeoutPulse) begin
         verdictNext.pass = 1'b0;  // timeout wins over anything earlier
         verdictNext.fail = 1'b1;
      end else if (!decided) begin
         if (matchBeat.hitPass) begin
            verdictNext.pass = 1'b1;  // pass beats fail on the same beat
         end else if (failNow) begin
            verdictNext.fail = 1'b1;
         end
      end
   end

   assign firstLatch = !decided && (verdictNext.pass || verdictNext.fail);

   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         stuckCnt <= '0;
         stuckOff <= 1'b0;
         verdict  <= '0;
      end else begin
         stuckCnt <= stuckCntNext;
         stuckOff <= stuckOffNext;
         verdict  <= verdictNext;
      end
   end

   // ------------------------------
   // core hold countdown
   // ------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         holdCnt  <= '0;
         coreHold <= 1'b0;
      end else if (stuckOffNext) begin
         holdCnt <= '0;  // checking disabled, the core keeps running
      end else if (firstLatch) begin
         holdCnt <= holdStart;
      end else if (holdCnt != '0) begin
         holdCnt <= holdCnt - 1'b1;
         if (holdCnt == holdWidth'(1)) coreHold <= 1'b1;  // sleepCycles edges after latch
      end
   end

   // ------------------------------
   // checks
   // ------------------------------
   verdictOneHot: assert property (
      @(posedge dvtFlags) disable iff (pcFail)
      !(verdict.pass && verdict.fail)
   ) else $error("verdictControl: pass and fail both set");

   // once held, the core stays held until the next reset
   holdSticky: assert property (
      @(posedge dvtFlags) disable iff (pcFail)
      coreHold |=> coreHold
   ) else $error("verdictControl: coreHold fell without reset");

endmodule

/* verif/pcMonTb.sv */
// testbench for pcMonTop: drives retired-PC traces per behavior and checks outputs against a reference model
module pcMonTb;

   localparam pcMonPkg::pc_t passPc    = 64'h0000_0000_8000_0100;
   localparam pcMonPkg::pc_t failPc    = 64'h0000_0000_8000_0200;
   localparam pcMonPkg::pc_t finishPc  = 64'h0000_0000_8000_0300;
   localparam pcMonPkg::pc_t toHostPc  = 64'h0000_0000_8000_1000;
   localparam pcMonPkg::pc_t failAltPc = 64'h0000_0000_8000_0400;
   localparam int stuckLimit  = 8;
   localparam int sleepCycles = 20;

   logic                 dvtFlags;
   logic                 pcFail;
   pcMonPkg::traceBeat_t trace;
   logic                 checkToHost;
   logic                 timeoutPulse;
   logic                 disableStuck;
   pcMonPkg::verdict_t   verdict;
   logic                 stuck;
   logic                 coreHold;

   int    errors   = 0;  // failed checks
   int    timeouts = 0;  // waits that ran out
   string testName = "start";

   pcMonTop #(
      .passAddr    (passPc),
      .failAddr    (failPc),
      .finishAddr  (finishPc),
      .toHostAddr  (toHostPc),
      .failAltAddr (failAltPc),
      .stuckLimit  (stuckLimit),
      .sleepCycles (sleepCycles)
   ) dut (
      .dvtFlags     (dvtFlags),
      .pcFail       (pcFail),
      .trace        (trace),
      .checkToHost  (checkToHost),
      .timeoutPulse (timeoutPulse),
      .disableStuck (disableStuck),
      .verdict      (verdict),
      .stuck        (stuck),
      .coreHold     (coreHold)
   );

   always #20 dvtFlags = ~dvtFlags;

   // ------------------------------
   // reference model
   // ------------------------------
   function automatic logic [pcMonPkg::matchBits-1:0] lowBits(input pcMonPkg::pc_t pc);
      return pc[pcMonPkg::matchBits-1:0];
   endfunction

   function automatic logic passHit(input pcMonPkg::pc_t pc, input logic toHostOn);
      return (lowBits(pc) == lowBits(passPc)) || (lowBits(pc) == lowBits(finishPc))
         || (toHostOn && lowBits(pc) == lowBits(toHostPc));
   endfunction

   function automatic logic failHit(input pcMonPkg::pc_t pc);
      return (lowBits(pc) == lowBits(failPc)) || (lowBits(pc) == lowBits(failAltPc));
   endfunction

   logic               aValid, aRepeat, haveLast;  // after capture edge
   pcMonPkg::pc_t      aPc, lastPc;
   logic               bValid, bRepeat, bPass, bFail;  // after match edge
   int                 stuckCount;
   int                 holdLeft;
   logic               offSeen;
   logic               expStuck, expHold;
   pcMonPkg::verdict_t expVerdict;

   // stages updated back to front so each sees the previous edge's values
   always @(posedge dvtFlags or posedge pcFail) begin : model
      int                 cntNext;
      logic               offNext;
      logic               stuckNow;
      pcMonPkg::verdict_t vNext;
      if (pcFail) begin
         {aValid, aRepeat, haveLast, bValid, bRepeat, bPass, bFail} = '0;
         {offSeen, expStuck, expHold} = '0;
         aPc = '0;
         lastPc = '0;
         stuckCount = 0;
         holdLeft = 0;
         expVerdict = '0;
      end else begin
         cntNext = stuckCount;
         if (bValid) cntNext = bRepeat ? cntNext + 1 : 0;
         offNext  = offSeen || disableStuck;
         stuckNow = (cntNext >= stuckLimit) && !offNext;
         vNext    = expVerdict;
         if (timeoutPulse) begin
            vNext = '{pass: 1'b0, fail: 1'b1};
         end else if (!expVerdict.pass && !expVerdict.fail) begin
            if (bPass) vNext.pass = 1'b1;
            else if (bFail || stuckNow) vNext.fail = 1'b1;
         end
         if (offNext) begin
            holdLeft = 0;
         end else if (!(expVerdict.pass || expVerdict.fail) && (vNext.pass || vNext.fail)) begin
            holdLeft = sleepCycles;  // first latch
         end else if (holdLeft > 0) begin
            holdLeft = holdLeft - 1;
            if (holdLeft == 0) expHold = 1'b1;
         end
         stuckCount = cntNext;
         offSeen    = offNext;
         expStuck   = stuckNow;
         expVerdict = vNext;
         bValid  = aValid;
         bRepeat = aValid && aRepeat;
         bPass   = aValid && passHit(aPc, checkToHost);
         bFail   = aValid && failHit(aPc);
         aValid  = trace.valid;
         aPc     = trace.pc;
         aRepeat = trace.valid && haveLast && (trace.pc == lastPc);
         if (trace.valid) begin
            haveLast = 1'b1;
            lastPc   = trace.pc;
         end
      end
   end

   // ------------------------------
   // checks, sampled mid-cycle
   // ------------------------------
   verdictCheck: assert property (@(negedge dvtFlags) disable iff (pcFail)
      verdict == expVerdict)
   else begin
      errors++;
      $display("Fail %s verdict expected %b actual %b", testName, expVerdict, verdict);
   end

   stuckCheck: assert property (@(negedge dvtFlags) disable iff (pcFail) stuck == expStuck)
   else begin
      errors++;
      $display("Fail %s stuck expected %b actual %b", testName, expStuck, stuck);
   end

   holdCheck: assert property (@(negedge dvtFlags) disable iff (pcFail) coreHold == expHold)
   else begin
      errors++;
      $display("Fail %s coreHold expected %b actual %b", testName, expHold, coreHold);
   end

   resetClear: assert property (@(negedge dvtFlags)
      pcFail |-> ({verdict, stuck, coreHold} == 4'b0000))
   else begin
      errors++;
      $display("Fail %s reset outputs expected 0000 actual %b", testName,
         {verdict, stuck, coreHold});
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   function automatic pcMonPkg::pc_t fillerPc();
      pcMonPkg::pc_t pc;
      pc = {$urandom, $urandom};
      pc[1:0] = 2'b10;  // table entries are word aligned
      return pc;
   endfunction

   task automatic applyReset(input string name);
      testName     = name;
      pcFail       = 1'b1;
      trace        = '0;
      checkToHost  = 1'b0;
      timeoutPulse = 1'b0;
      disableStuck = 1'b0;
      repeat (3) @(negedge dvtFlags);
      pcFail = 1'b0;
   endtask

   task automatic sendPc(input pcMonPkg::pc_t pc);
      @(negedge dvtFlags);
      trace = '{valid: 1'b1, pc: pc};
   endtask

   task automatic sendFiller(input int count);
      repeat (count) sendPc(fillerPc());
   endtask

   task automatic idleCycles(input int count);
      repeat (count) begin
         @(negedge dvtFlags);
         trace.valid = 1'b0;
      end
   endtask

   function automatic bit condNow(input string what);
      case (what)
         "pass":  return verdict.pass;
         "fail":  return verdict.fail;
         "stuck": return stuck;
         default: return coreHold;
      endcase
   endfunction

   task automatic waitFor(input string what, input int limit);
      int n;
      n = 0;
      while (!condNow(what) && n < limit) begin
         @(negedge dvtFlags);
         n++;
      end
      if (!condNow(what)) begin
         timeouts++;
         $display("%s: %s did not show up within %0d cycles", testName, what, limit);
      end
   endtask

   // ------------------------------
   // behaviors
   // ------------------------------
   initial begin
      void'($urandom(20));
      dvtFlags = 1'b0;
      applyReset("passVerdict");
      sendFiller(6);
      sendPc(passPc);
      idleCycles(1);
      waitFor("pass", 10);
      waitFor("hold", sleepCycles + 10);

      applyReset("finishVerdict");
      sendFiller(3);
      sendPc(finishPc);
      idleCycles(1);
      waitFor("pass", 10);

      applyReset("failVerdict");
      sendFiller(4);
      sendPc(failPc);
      sendFiller(2);
      sendPc(passPc);  // must not override the fail
      idleCycles(6);
      waitFor("fail", 10);

      applyReset("failAltVerdict");
      sendFiller(3);
      sendPc(failAltPc);
      idleCycles(1);
      waitFor("fail", 10);

      applyReset("toHost");
      sendPc(toHostPc);  // ignored while checkToHost is low
      idleCycles(6);
      @(negedge dvtFlags);
      checkToHost = 1'b1;
      sendPc(toHostPc);
      idleCycles(1);
      waitFor("pass", 10);

      applyReset("stuckCore");
      sendFiller(3);
      repeat (stuckLimit + 1) sendPc(64'h0000_0000_1234_5678);
      idleCycles(1);
      waitFor("stuck", 10);
      waitFor("fail", 10);
      waitFor("hold", sleepCycles + 10);

      applyReset("stuckDisabled");
      @(negedge dvtFlags);
      disableStuck = 1'b1;
      @(negedge dvtFlags);
      disableStuck = 1'b0;
      repeat (stuckLimit + 1) sendPc(64'h0000_0000_1234_5678);
      sendPc(passPc);
      idleCycles(1);
      waitFor("pass", 10);
      idleCycles(sleepCycles + 10);  // hold must stay low

      applyReset("timeoutOverride");
      sendFiller(2);
      sendPc(passPc);
      idleCycles(1);
      waitFor("pass", 10);
      @(negedge dvtFlags);
      timeoutPulse = 1'b1;
      @(negedge dvtFlags);
      timeoutPulse = 1'b0;
      waitFor("fail", 10);
      idleCycles(4);

      applyReset("finalReset");
      idleCycles(2);

      $display("check failures: %0d, wait timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
